// File: src/timer_pkg.sv
// shared widths, register map and timer word type; single hart, fixed 32-bit APB map only
`default_nettype none

package timer_pkg;

	// bus geometry, fixed by the memory map
	localparam int W_ADDR = 8;   // byte address into the timer block
	localparam int W_DATA = 32;  // APB data width
	localparam int W_TIME = 64;  // mtime / mtimecmp width per the privileged spec

	// register map, word aligned
	localparam logic [W_ADDR-1:0] ADDR_CTRL      = 8'h00;  // bit 0 = count enable
	localparam logic [W_ADDR-1:0] ADDR_MTIME     = 8'h08;  // mtime low word
	localparam logic [W_ADDR-1:0] ADDR_MTIMEH    = 8'h0c;  // mtime high word
	localparam logic [W_ADDR-1:0] ADDR_MTIMECMP  = 8'h10;  // mtimecmp low word
	localparam logic [W_ADDR-1:0] ADDR_MTIMECMPH = 8'h14;  // mtimecmp high word

	// counting runs straight out of reset
	localparam logic CTRL_EN_RESET = 1'b1;

	// two bus-sized halves, hi first so it lands in the upper bits
	typedef struct packed {
		logic [W_DATA-1:0] hi;  // bits 63:32
		logic [W_DATA-1:0] lo;  // bits 31:0
	} timer_half_t;

	// one 64-bit timer word seen two ways:
	// flat for the increment and the compare,
	// half for the 32-bit bus accesses
	typedef union packed {
		logic [W_TIME-1:0] flat;  // whole value, arithmetic view
		timer_half_t       half;  // split view, register access
	} timer_word_u;

endpackage

`default_nettype wire

// File: src/sync_1bit.sv
// two-flop synchronizer for one slow async level; input must be stable for >1 clk to be seen
`timescale 1ns/1ns
`default_nettype none

module sync_1bit (
	input  wire clk,
	input  wire rst_n,
	input  wire i,  // asynchronous to clk
	output wire o   // clk-domain copy, 2-3 edges late
);

	logic meta;  // first stage, may go metastable
	logic stab;  // second stage, settled

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			meta <= 1'b0;
			stab <= 1'b0;
		end else begin
			meta <= i;
			stab <= meta;  // one full cycle to resolve
		end
	end

	assign o = stab;

	// downstream logic never sees X out of the chain once reset is gone
	a_no_x_out: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(o));

endmodule

`default_nettype wire

// File: src/tick_gen.sv
// tick_nrz edge detector; each tick_nrz level must last >= 3 clk or edges merge or drop
`timescale 1ns/1ns
`default_nettype none

module tick_gen (
	input  wire clk,
	input  wire rst_n,
	input  wire tick_nrz,  // external timebase, both edges count
	input  wire en,        // ctrl enable from the register block
	input  wire dbg_halt,  // debugger freezes the count
	output wire tick       // single-cycle count pulse
);

	logic tick_sync;  // tick_nrz in clk domain
	logic tick_prev;  // last synchronized level
	logic edge_seen;

	sync_1bit i_sync (
		.clk   (clk),
		.rst_n (rst_n),
		.i     (tick_nrz),
		.o     (tick_sync)
	);

	// level history for the edge compare
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tick_prev <= 1'b0;
		else
			tick_prev <= tick_sync;
	end

	assign edge_seen = tick_prev != tick_sync;  // rising or falling, either counts

	// edges that arrive while disabled or halted are dropped, not queued
	assign tick = edge_seen && en && !dbg_halt;

	// a held tick_nrz level gives at most one pulse per edge
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick);

endmodule

`default_nettype wire

// File: src/timer_compare.sv
// mtimecmp register and registered compare; unsigned 64-bit test, irq lags inputs by one clk
`timescale 1ns/1ns
`default_nettype none

module timer_compare
	import timer_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire timer_word_u   mtime,     // live counter value
	input  wire                wr_lo,     // load low half of mtimecmp
	input  wire                wr_hi,     // load high half of mtimecmp
	input  wire [W_DATA-1:0]   wdata,     // bus write data
	output timer_word_u        mtimecmp,  // back to the read mux
	output logic               timer_irq  // level, stays up while mtime >= mtimecmp
);

	logic irq_nxt;

	// software usually writes the halves in sequence, so a spurious
	// irq may show between the two writes; standard RISC-V behaviour
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp.flat <= '0;
		end else begin
			if (wr_lo)
				mtimecmp.half.lo <= wdata;
			if (wr_hi)
				mtimecmp.half.hi <= wdata;
		end
	end

	// full 64-bit unsigned compare, flat view
	assign irq_nxt = mtime.flat >= mtimecmp.flat;

	// registered to keep the wide comparator off the irq path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			timer_irq <= 1'b0;  // goes high 1 clk after reset, 0 >= 0
		else
			timer_irq <= irq_nxt;
	end

	// the decoder only ever hits one address per access
	a_one_half_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_lo && wr_hi));

endmodule

`default_nettype wire

// File: src/riscv_timer.sv
// APB machine timer; no wait states, no byte strobes, one hart, unmapped access -> pslverr
`timescale 1ns/1ns
`default_nettype none

module riscv_timer
	import timer_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,

	// APB slave
	input  wire               psel,
	input  wire               penable,
	input  wire               pwrite,
	input  wire [W_ADDR-1:0]  paddr,
	input  wire [W_DATA-1:0]  pwdata,
	output logic [W_DATA-1:0] prdata,   // combinational from paddr
	output wire               pready,   // tied high
	output wire               pslverr,  // unmapped address

	input  wire               dbg_halt,  // freeze count while debugger holds the core
	input  wire               tick_nrz,  // async timebase, both edges count

	output wire               timer_irq
);

	logic        bus_access;  // access phase of any transfer
	logic        bus_write;   // access phase of a write

	// address decode
	logic        sel_ctrl;
	logic        sel_mtime;
	logic        sel_mtimeh;
	logic        sel_mtimecmp;
	logic        sel_mtimecmph;
	logic        addr_hit;    // any of the five mapped words

	logic        ctrl_en;     // count enable, ctrl bit 0
	logic        tick;        // one count step from tick_gen

	timer_word_u mtime;
	timer_word_u mtime_nxt;
	timer_word_u mtimecmp;    // owned by timer_compare

	// setup phase does nothing, everything happens in the access cycle
	assign bus_access = psel && penable;
	assign bus_write  = bus_access && pwrite;

	always_comb begin
		sel_ctrl      = 1'b0;
		sel_mtime     = 1'b0;
		sel_mtimeh    = 1'b0;
		sel_mtimecmp  = 1'b0;
		sel_mtimecmph = 1'b0;
		case (paddr)
			ADDR_CTRL:      sel_ctrl      = 1'b1;
			ADDR_MTIME:     sel_mtime     = 1'b1;
			ADDR_MTIMEH:    sel_mtimeh    = 1'b1;
			ADDR_MTIMECMP:  sel_mtimecmp  = 1'b1;
			ADDR_MTIMECMPH: sel_mtimecmph = 1'b1;
			default: ;  // hole in the map
		endcase
	end

	assign addr_hit = sel_ctrl || sel_mtime || sel_mtimeh || sel_mtimecmp || sel_mtimecmph;

	// no wait states, so the error is reported in the same access cycle
	assign pready  = 1'b1;
	assign pslverr = bus_access && !addr_hit;  // read or write alike

	// control register, only bit 0 is stored
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ctrl_en <= CTRL_EN_RESET;
		else if (bus_write && sel_ctrl)
			ctrl_en <= pwdata[0];  // upper bits ignored
	end

	// edge detect and gating of the external timebase
	tick_gen i_tick_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick_nrz (tick_nrz),
		.en       (ctrl_en),
		.dbg_halt (dbg_halt),
		.tick     (tick)
	);

	// increment first over all 64 bits, then let a bus write replace
	// its own half; the carry into the other half still goes through
	always_comb begin
		mtime_nxt.flat = mtime.flat + {{(W_TIME-1){1'b0}}, tick};
		if (bus_write && sel_mtime)
			mtime_nxt.half.lo = pwdata;
		if (bus_write && sel_mtimeh)
			mtime_nxt.half.hi = pwdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mtime.flat <= '0;
		else
			mtime <= mtime_nxt;
	end

	// comparator and irq register
	timer_compare i_timer_compare (
		.clk       (clk),
		.rst_n     (rst_n),
		.mtime     (mtime),
		.wr_lo     (bus_write && sel_mtimecmp),
		.wr_hi     (bus_write && sel_mtimecmph),
		.wdata     (pwdata),
		.mtimecmp  (mtimecmp),
		.timer_irq (timer_irq)
	);

	// read mux, no side effects on read
	always_comb begin
		prdata = '0;  // unmapped reads return zero
		if (sel_ctrl)
			prdata = {{(W_DATA-1){1'b0}}, ctrl_en};
		if (sel_mtime)
			prdata = mtime.half.lo;
		if (sel_mtimeh)
			prdata = mtime.half.hi;
		if (sel_mtimecmp)
			prdata = mtimecmp.half.lo;
		if (sel_mtimecmph)
			prdata = mtimecmp.half.hi;
	end

	// master must open every transfer with a setup phase
	a_penable_in_psel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel);

endmodule

`default_nettype wire

// File: src/timer_subsys.sv
// timer top level; pready is constant high and tick_nrz may be fully asynchronous to clk
`timescale 1ns/1ns
`default_nettype none

module timer_subsys
	import timer_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,

	// APB slave port
	input  wire               psel,
	input  wire               penable,
	input  wire               pwrite,
	input  wire [W_ADDR-1:0]  paddr,
	input  wire [W_DATA-1:0]  pwdata,
	output wire [W_DATA-1:0]  prdata,
	output wire               pready,
	output wire               pslverr,

	input  wire               dbg_halt,  // from the debug module
	input  wire               tick_nrz,  // external timebase
	output wire               timer_irq  // to the core's MTIP
);

	riscv_timer i_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.tick_nrz  (tick_nrz),
		.timer_irq (timer_irq)
	);

endmodule

`default_nettype wire

// File: verif/tb_timer_model.svh
// timer reference model for tb_timer; include inside a module that imports timer_pkg, one hart only
`ifndef TB_TIMER_MODEL_SVH
`define TB_TIMER_MODEL_SVH

logic        m_ctrl;   // expected count enable
timer_word_u m_mtime;  // expected mtime, advanced by counted toggles
timer_word_u m_cmp;    // expected mtimecmp

// 32-bit LCG step, numerical recipes constants
function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// the five words of the register map
function automatic logic addr_mapped(input logic [W_ADDR-1:0] a);
	return (a == ADDR_CTRL) || (a == ADDR_MTIME) || (a == ADDR_MTIMEH) ||
		(a == ADDR_MTIMECMP) || (a == ADDR_MTIMECMPH);
endfunction

// what a read of a should return right now
function automatic logic [W_DATA-1:0] exp_read(input logic [W_ADDR-1:0] a);
	case (a)
		ADDR_CTRL:      return {{(W_DATA-1){1'b0}}, m_ctrl};  // only bit 0 kept
		ADDR_MTIME:     return m_mtime.half.lo;
		ADDR_MTIMEH:    return m_mtime.half.hi;
		ADDR_MTIMECMP:  return m_cmp.half.lo;
		ADDR_MTIMECMPH: return m_cmp.half.hi;
		default:        return '0;  // holes read as zero
	endcase
endfunction

// level interrupt, unsigned 64-bit compare
function automatic logic exp_irq();
	return m_mtime.flat >= m_cmp.flat;
endfunction

function automatic void model_reset();
	m_ctrl       = CTRL_EN_RESET;
	m_mtime.flat = '0;
	m_cmp.flat   = '0;
endfunction

// bus write effect, unmapped writes are dropped
function automatic void model_write(input logic [W_ADDR-1:0] a, input logic [W_DATA-1:0] d);
	case (a)
		ADDR_CTRL:      m_ctrl = d[0];
		ADDR_MTIME:     m_mtime.half.lo = d;
		ADDR_MTIMEH:    m_mtime.half.hi = d;
		ADDR_MTIMECMP:  m_cmp.half.lo = d;
		ADDR_MTIMECMPH: m_cmp.half.hi = d;
		default: ;
	endcase
endfunction

// one tick_nrz edge, counted only when enabled and not halted
function automatic void model_tick(input logic halted);
	if (m_ctrl && !halted)
		m_mtime.flat = m_mtime.flat + 64'd1;  // carry runs through both halves
endfunction

`endif

// File: verif/tb_timer.sv
// self-checking testbench for timer_subsys; tick_nrz levels held 5 clk, reads taken on a quiet line
`timescale 1ns/1ns
`default_nettype none

module tb_timer
	import timer_pkg::*;
();

	localparam int CLK_PERIOD  = 40;
	localparam int RST_CYCLES  = 16;
	localparam int HOLD        = 5;    // clk cycles per tick_nrz level
	localparam int N_STEPS     = 250;  // upper bound on accesses plus toggles
	localparam int STEP_CYCLES = 7;    // worst step is a toggle with its hold
	localparam int MARGIN      = 200;
	localparam longint WATCHDOG_NS = (RST_CYCLES + N_STEPS * STEP_CYCLES + MARGIN) * CLK_PERIOD;
	localparam int K_DATA = 0;  // check kinds
	localparam int K_ERR  = 1;
	localparam int K_IRQ  = 2;
	localparam int K_RDY  = 3;

	logic              clk;
	logic              rst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [W_ADDR-1:0] paddr;
	logic [W_DATA-1:0] pwdata;
	wire  [W_DATA-1:0] prdata;
	wire               pready;
	wire               pslverr;
	logic              dbg_halt;
	logic              tick_nrz;
	wire               timer_irq;

	logic [31:0]       rng;      // LCG state
	int                err_cnt;
	int                chk_cnt;
	int                chk_kind_q[$];  // pending checks for the compare process
	logic [W_DATA-1:0] chk_got_q[$];
	logic [W_DATA-1:0] chk_exp_q[$];
	logic [W_ADDR-1:0] chk_addr_q[$];
	event              chk_ev;
	logic [W_DATA-1:0] r;

	`include "tb_timer_model.svh"

	timer_subsys i_timer_subsys (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.tick_nrz  (tick_nrz),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = !clk;
	end

	function automatic logic [31:0] next_rand();
		rng = lcg_step(rng);
		return rng;
	endfunction

	function automatic string kind_name(input int k);
		if (k == K_DATA)
			return "prdata";
		if (k == K_ERR)
			return "pslverr";
		if (k == K_RDY)
			return "pready";
		return "timer_irq";
	endfunction

	task automatic push_check(input int k, input logic [W_DATA-1:0] got,
			input logic [W_DATA-1:0] exp, input logic [W_ADDR-1:0] a);
		chk_kind_q.push_back(k);
		chk_got_q.push_back(got);
		chk_exp_q.push_back(exp);
		chk_addr_q.push_back(a);
		-> chk_ev;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// write lands on the edge that closes the access cycle
	task automatic apb_write(input logic [W_ADDR-1:0] a, input logic [W_DATA-1:0] d);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= a;
		pwdata  <= d;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);  // pslverr and pready settle mid access phase
		push_check(K_ERR, {31'b0, pslverr}, {31'b0, !addr_mapped(a)}, a);
		push_check(K_RDY, {31'b0, pready}, 32'h1, a);  // slave has no wait states
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		model_write(a, d);
	endtask

	task automatic apb_read(input logic [W_ADDR-1:0] a);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= a;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		push_check(K_DATA, prdata, exp_read(a), a);
		push_check(K_ERR, {31'b0, pslverr}, {31'b0, !addr_mapped(a)}, a);
		push_check(K_RDY, {31'b0, pready}, 32'h1, a);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_irq();
		@(negedge clk);
		push_check(K_IRQ, {31'b0, timer_irq}, {31'b0, exp_irq()}, '0);
	endtask

	task automatic check_all_regs();
		apb_read(ADDR_CTRL);
		apb_read(ADDR_MTIME);
		apb_read(ADDR_MTIMEH);
		apb_read(ADDR_MTIMECMP);
		apb_read(ADDR_MTIMECMPH);
	endtask

	// n edges of tick_nrz followed by one extra cycle so the line stays quiet for HOLD cycles
	task automatic toggle_tick(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			tick_nrz <= !tick_nrz;
			model_tick(dbg_halt);  // gating state is held across the whole hold
			wait_cycles(HOLD - 1);
		end
		wait_cycles(1);
	endtask

	// drains the check queue and compares each entry
	initial begin
		int                k;
		logic [W_DATA-1:0] got;
		logic [W_DATA-1:0] exp;
		logic [W_ADDR-1:0] a;
		forever begin
			@(chk_ev);
			while (chk_kind_q.size() > 0) begin
				k   = chk_kind_q.pop_front();
				got = chk_got_q.pop_front();
				exp = chk_exp_q.pop_front();
				a   = chk_addr_q.pop_front();
				chk_cnt++;
				if (got !== exp) begin
					err_cnt++;
					$display("FAILED @%0t: %s at addr 0x%02h, got 0x%08h, expected 0x%08h",
						$time, kind_name(k), a, got, exp);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t before the test sequence finished", $time);
		$display("Simulation failed");
		$finish;
	end

	// stimulus
	initial begin
		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;
		tick_nrz = 1'b0;
		rng      = 32'hae7e518e;
		err_cnt  = 0;
		chk_cnt  = 0;
		model_reset();
		wait_cycles(RST_CYCLES);
		rst_n <= 1'b1;

		// irq is up after reset since 0 >= 0
		wait_cycles(2);
		check_irq();
		check_all_regs();

		// random register readback
		for (int i = 0; i < 6; i++) begin
			apb_write(ADDR_CTRL, next_rand());
			apb_read(ADDR_CTRL);
			apb_write(ADDR_MTIME, next_rand());
			apb_read(ADDR_MTIME);
			apb_write(ADDR_MTIMEH, next_rand());
			apb_read(ADDR_MTIMEH);
			apb_write(ADDR_MTIMECMP, next_rand());
			apb_read(ADDR_MTIMECMP);
			apb_write(ADDR_MTIMECMPH, next_rand());
			apb_read(ADDR_MTIMECMPH);
		end
		// holes in the map including an unaligned one
		apb_write(8'h04, next_rand());
		apb_read(8'h04);
		apb_write(8'h18, next_rand());
		apb_read(8'h18);
		apb_write(8'h0b, next_rand());
		apb_read(8'h0b);
		apb_write(8'hfc, next_rand());
		apb_read(8'hfc);
		check_all_regs();  // nothing moved
		apb_write(ADDR_CTRL, 32'h1);

		// both edges count until ctrl is cleared or the core is halted
		apb_write(ADDR_MTIME, 32'h0000_0100);
		apb_write(ADDR_MTIMEH, 32'h0000_0001);
		toggle_tick(6);
		apb_read(ADDR_MTIME);
		apb_read(ADDR_MTIMEH);
		apb_write(ADDR_CTRL, 32'h0);
		toggle_tick(4);
		apb_read(ADDR_MTIME);
		apb_write(ADDR_CTRL, 32'h1);
		@(posedge clk);
		dbg_halt <= 1'b1;
		toggle_tick(4);
		dbg_halt <= 1'b0;
		apb_read(ADDR_MTIME);
		toggle_tick(3);  // counting resumes
		apb_read(ADDR_MTIME);
		apb_read(ADDR_MTIMEH);

		// static compare where every fourth pass is exactly equal
		for (int i = 0; i < 8; i++) begin
			apb_write(ADDR_MTIME, next_rand());
			apb_write(ADDR_MTIMEH, next_rand());
			apb_write(ADDR_MTIMECMP, (i % 4 == 0) ? m_mtime.half.lo : next_rand());
			apb_write(ADDR_MTIMECMPH, (i % 2 == 0) ? m_mtime.half.hi : next_rand());
			wait_cycles(2);
			check_irq();
		end

		// carry out of the low half with irq expected at start + 2
		r = next_rand();
		apb_write(ADDR_MTIMECMPH, r + 32'd1);
		apb_write(ADDR_MTIMECMP, 32'h0);
		apb_write(ADDR_MTIME, 32'hffff_fffe);
		apb_write(ADDR_MTIMEH, r);
		wait_cycles(2);
		check_irq();
		for (int i = 0; i < 4; i++) begin
			toggle_tick(1);
			check_irq();
		end
		apb_read(ADDR_MTIME);  // wrapped to 2
		apb_read(ADDR_MTIMEH);

		wait_cycles(2);  // let the compare process drain
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+verif
src/timer_pkg.sv
src/sync_1bit.sv
src/tick_gen.sv
src/timer_compare.sv
src/riscv_timer.sv
src/timer_subsys.sv
verif/tb_timer.sv
